//--- hdl/lbp_pkg.sv
package lbp_pkg;

  localparam int IMG_W      = 16;
  localparam int IMG_H      = 12;
  localparam int LBP_RADIUS = 2;
  localparam int WIN_SIZE   = 2 * LBP_RADIUS + 1;
  localparam int RING_PTS   = 8;
  localparam int PIX_W      = 8;
  localparam int FRAC_W     = 16;
  localparam int BILIN_LAT  = 3;

  typedef logic [PIX_W-1:0]          pixel_t;
  typedef logic [PIX_W+FRAC_W-1:0]   sample_t;
  typedef logic [FRAC_W:0]           weight_t;
  typedef logic [RING_PTS-1:0]       lbp_code_t;
  typedef logic [$clog2(IMG_W)-1:0]  col_t;
  typedef logic [$clog2(IMG_H)-1:0]  row_t;

  // Corner weights for f = sqrt(2) - 1, summing to exactly 65536
  localparam weight_t W_NEAR = 17'd22488;
  localparam weight_t W_MID  = 17'd15902;
  localparam weight_t W_FAR  = 17'd11244;

  typedef struct packed {
    pixel_t inner;
    pixel_t outer_col;
    pixel_t outer_row;
    pixel_t outer_diag;
  } corner_quad_t;

  typedef struct packed {
    pixel_t       center;
    pixel_t       east;
    pixel_t       north;
    pixel_t       west;
    pixel_t       south;
    corner_quad_t ne;
    corner_quad_t nw;
    corner_quad_t sw;
    corner_quad_t se;
    logic         valid;
    logic         frame_end;
  } lbp_nbhd_t;

  // s[0] is east, then counter-clockwise in 45 degree steps
  typedef struct packed {
    sample_t                    center_ext;
    sample_t [RING_PTS-1:0]     s;
    logic                       valid;
    logic                       frame_end;
  } lbp_ring_t;

endpackage

//--- hdl/lbp_bilinear_calc.sv
`timescale 1ns/1ps

module lbp_bilinear_calc (
  input  logic                  clk,
  input  logic                  rst_n,
  input  lbp_pkg::corner_quad_t quad_i,
  output lbp_pkg::sample_t      sample_o
);

  import lbp_pkg::*;

  sample_t prod_q [4];
  sample_t pair_q [2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_q   <= '{default: '0};
      pair_q   <= '{default: '0};
      sample_o <= '0;
    end else begin
      // Largest product is 255 * W_NEAR, well inside 24 bits
      prod_q[0] <= sample_t'(quad_i.inner) * sample_t'(W_NEAR);
      prod_q[1] <= sample_t'(quad_i.outer_col) * sample_t'(W_MID);
      prod_q[2] <= sample_t'(quad_i.outer_row) * sample_t'(W_MID);
      prod_q[3] <= sample_t'(quad_i.outer_diag) * sample_t'(W_FAR);

      pair_q[0] <= prod_q[0] + prod_q[1];
      pair_q[1] <= prod_q[2] + prod_q[3];

      // Weights sum to 1.0 so the total stays below 256.0
      sample_o  <= pair_q[0] + pair_q[1];
    end
  end

endmodule

//--- hdl/lbp_window_buffer.sv
`timescale 1ns/1ps

module lbp_window_buffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pixel_valid_i,
  input  lbp_pkg::pixel_t    pixel_i,
  input  logic               frame_start_i,
  output lbp_pkg::lbp_nbhd_t nbhd_o
);

  import lbp_pkg::*;

  // Line buffer 0 holds the oldest row
  pixel_t    line_buf [WIN_SIZE-1][IMG_W];
  pixel_t    win      [WIN_SIZE][WIN_SIZE];
  pixel_t    new_col  [WIN_SIZE];

  col_t      col_q;
  col_t      cur_col;
  row_t      row_q;
  row_t      cur_row;
  logic      last_col;
  logic      last_row;
  logic      win_valid_q;
  logic      win_end_q;

  // Frame start puts the pixel at the origin
  always_comb begin
    cur_col  = frame_start_i ? '0 : col_q;
    cur_row  = frame_start_i ? '0 : row_q;
    last_col = (cur_col == col_t'(IMG_W - 1));
    last_row = (cur_row == row_t'(IMG_H - 1));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pixel_valid_i) begin
      if (last_col) begin
        col_q <= '0;
        row_q <= last_row ? '0 : cur_row + row_t'(1);
      end else begin
        col_q <= cur_col + col_t'(1);
        row_q <= cur_row;
      end
    end
  end

  // Column entering the window, oldest row first
  always_comb begin
    for (int i = 0; i < WIN_SIZE - 1; i++) begin
      new_col[i] = line_buf[i][cur_col];
    end
    new_col[WIN_SIZE-1] = pixel_i;
  end

  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int i = 0; i < WIN_SIZE - 1; i++) begin
        line_buf[i][cur_col] <= new_col[i + 1];
      end
      for (int i = 0; i < WIN_SIZE; i++) begin
        for (int j = 0; j < WIN_SIZE - 1; j++) begin
          win[i][j] <= win[i][j + 1];
        end
        win[i][WIN_SIZE-1] <= new_col[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_q <= 1'b0;
      win_end_q   <= 1'b0;
    end else begin
      win_valid_q <= pixel_valid_i && (cur_row >= row_t'(2 * LBP_RADIUS)) &&
                     (cur_col >= col_t'(2 * LBP_RADIUS));
      win_end_q   <= pixel_valid_i && last_row && last_col;
    end
  end

  // Row 0 is north, column 4 is east
  always_comb begin
    nbhd_o.center           = win[LBP_RADIUS][LBP_RADIUS];
    nbhd_o.east             = win[2][4];
    nbhd_o.north            = win[0][2];
    nbhd_o.west             = win[2][0];
    nbhd_o.south            = win[4][2];
    nbhd_o.ne.inner         = win[1][3];
    nbhd_o.ne.outer_col     = win[1][4];
    nbhd_o.ne.outer_row     = win[0][3];
    nbhd_o.ne.outer_diag    = win[0][4];
    nbhd_o.nw.inner         = win[1][1];
    nbhd_o.nw.outer_col     = win[1][0];
    nbhd_o.nw.outer_row     = win[0][1];
    nbhd_o.nw.outer_diag    = win[0][0];
    nbhd_o.sw.inner         = win[3][1];
    nbhd_o.sw.outer_col     = win[3][0];
    nbhd_o.sw.outer_row     = win[4][1];
    nbhd_o.sw.outer_diag    = win[4][0];
    nbhd_o.se.inner         = win[3][3];
    nbhd_o.se.outer_col     = win[3][4];
    nbhd_o.se.outer_row     = win[4][3];
    nbhd_o.se.outer_diag    = win[4][4];
    nbhd_o.valid            = win_valid_q;
    nbhd_o.frame_end        = win_end_q;
  end

endmodule

//--- hdl/lbp_ring_interp.sv
`timescale 1ns/1ps

module lbp_ring_interp (
  input  logic               clk,
  input  logic               rst_n,
  input  lbp_pkg::lbp_nbhd_t nbhd_i,
  output lbp_pkg::lbp_ring_t ring_o
);

  import lbp_pkg::*;

  // Axis slots: center, east, north, west, south
  pixel_t [4:0]          axis_in;
  pixel_t [4:0]          axis_sr [BILIN_LAT];
  logic [BILIN_LAT-1:0]  valid_sr;
  logic [BILIN_LAT-1:0]  end_sr;
  corner_quad_t          quad [4];
  sample_t               diag [4];

  function automatic sample_t widen(pixel_t p);
    return {p, {FRAC_W{1'b0}}};
  endfunction

  always_comb begin
    axis_in = {nbhd_i.south, nbhd_i.west, nbhd_i.north, nbhd_i.east, nbhd_i.center};
    quad[0] = nbhd_i.ne;
    quad[1] = nbhd_i.nw;
    quad[2] = nbhd_i.sw;
    quad[3] = nbhd_i.se;
  end

  for (genvar k = 0; k < 4; k++) begin : g_diag
    lbp_bilinear_calc bilin_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .quad_i   (quad[k]),
      .sample_o (diag[k])
    );
  end

  // Axis pixels wait out the bilinear latency
  always_ff @(posedge clk) begin
    axis_sr[0] <= axis_in;
    for (int i = 1; i < BILIN_LAT; i++) begin
      axis_sr[i] <= axis_sr[i - 1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_sr <= '0;
      end_sr   <= '0;
    end else begin
      valid_sr <= {valid_sr[BILIN_LAT-2:0], nbhd_i.valid};
      end_sr   <= {end_sr[BILIN_LAT-2:0], nbhd_i.frame_end};
    end
  end

  // Even steps are axis samples, odd steps diagonal
  always_comb begin
    ring_o.center_ext = widen(axis_sr[BILIN_LAT-1][0]);
    for (int k = 0; k < 4; k++) begin
      ring_o.s[2 * k]     = widen(axis_sr[BILIN_LAT-1][k + 1]);
      ring_o.s[2 * k + 1] = diag[k];
    end
    ring_o.valid     = valid_sr[BILIN_LAT-1];
    ring_o.frame_end = end_sr[BILIN_LAT-1];
  end

endmodule

//--- hdl/lbp_encoder.sv
`timescale 1ns/1ps

module lbp_encoder (
  input  logic               clk,
  input  logic               rst_n,
  input  lbp_pkg::lbp_ring_t ring_i,
  output logic               code_valid_o,
  output lbp_pkg::lbp_code_t code_o,
  output logic               frame_done_o
);

  import lbp_pkg::*;

  lbp_code_t code_d;

  // Ties count as set
  always_comb begin
    for (int i = 0; i < RING_PTS; i++) begin
      code_d[i] = (ring_i.s[i] >= ring_i.center_ext);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid_o <= 1'b0;
      code_o       <= '0;
      frame_done_o <= 1'b0;
    end else begin
      code_valid_o <= ring_i.valid;
      frame_done_o <= ring_i.valid && ring_i.frame_end;
      if (ring_i.valid) begin
        code_o <= code_d;
      end
    end
  end

endmodule

//--- hdl/lbp_top.sv
`timescale 1ns/1ps

module lbp_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pixel_valid_i,
  input  lbp_pkg::pixel_t    pixel_i,
  input  logic               frame_start_i,
  output logic               code_valid_o,
  output lbp_pkg::lbp_code_t code_o,
  output logic               frame_done_o
);

  import lbp_pkg::*;

  lbp_nbhd_t nbhd;
  lbp_ring_t ring;

  lbp_window_buffer window_buffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_valid_i (pixel_valid_i),
    .pixel_i       (pixel_i),
    .frame_start_i (frame_start_i),
    .nbhd_o        (nbhd)
  );

  // Three cycles, matching BILIN_LAT
  lbp_ring_interp ring_interp_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .nbhd_i (nbhd),
    .ring_o (ring)
  );

  lbp_encoder encoder_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ring_i       (ring),
    .code_valid_o (code_valid_o),
    .code_o       (code_o),
    .frame_done_o (frame_done_o)
  );

endmodule

//--- tb/lbp_top_sva.sv
`timescale 1ns/1ps

module lbp_top_sva (
  input logic               clk,
  input logic               rst_n,
  input logic               pixel_valid_i,
  input logic               frame_start_i,
  input logic               code_valid_i,
  input lbp_pkg::lbp_code_t code_i,
  input logic               frame_done_i
);

  import lbp_pkg::*;

  col_t col_q;
  col_t cur_col;
  row_t row_q;
  row_t cur_row;
  logic completes;
  logic ends_frame;
  bit   reset_fail;
  bit   latency_fail;
  bit   done_fail;
  logic any_fail;

  // Raster position of the pixel offered this cycle
  always_comb begin
    cur_col    = frame_start_i ? '0 : col_q;
    cur_row    = frame_start_i ? '0 : row_q;
    completes  = pixel_valid_i && (cur_row >= row_t'(2 * LBP_RADIUS)) &&
                 (cur_col >= col_t'(2 * LBP_RADIUS));
    ends_frame = pixel_valid_i && (cur_row == row_t'(IMG_H - 1)) &&
                 (cur_col == col_t'(IMG_W - 1));
    any_fail   = reset_fail | latency_fail | done_fail;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pixel_valid_i) begin
      if (cur_col == col_t'(IMG_W - 1)) begin
        col_q <= '0;
        row_q <= (cur_row == row_t'(IMG_H - 1)) ? '0 : cur_row + row_t'(1);
      end else begin
        col_q <= cur_col + col_t'(1);
        row_q <= cur_row;
      end
    end
  end

  a_reset_clears: assert property (@(posedge clk)
    $past(!rst_n) |-> (!code_valid_i && !frame_done_i && code_i == '0))
    else begin
      reset_fail = 1'b1;
      $error("outputs not cleared by reset");
    end

  // Window, ring and encoder stages add up to 5 cycles
  a_code_latency: assert property (@(posedge clk) disable iff (!rst_n)
    code_valid_i == $past(completes, 5))
    else begin
      latency_fail = 1'b1;
      $error("code_valid_o not 5 cycles after completing pixel");
    end

  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done_i == $past(ends_frame, 5))
    else begin
      done_fail = 1'b1;
      $error("frame_done_o not 5 cycles after last pixel");
    end

endmodule

bind lbp_top lbp_top_sva lbp_top_sva_inst (
  .clk           (clk),
  .rst_n         (rst_n),
  .pixel_valid_i (pixel_valid_i),
  .frame_start_i (frame_start_i),
  .code_valid_i  (code_valid_o),
  .code_i        (code_o),
  .frame_done_i  (frame_done_o)
);

//--- tb/tb_lbp_top.sv
`timescale 1ns/1ps

module tb_lbp_top;

  import lbp_pkg::*;

  // Gapped frame needs up to 4 cycles per pixel, so 3 frames fit well inside
  localparam int CYCLE_LIMIT = 2500;
  localparam int FRAMES      = 3;

  logic      clk;
  logic      rst_n;
  logic      pixel_valid;
  pixel_t    pixel;
  logic      frame_start;
  logic      code_valid;
  lbp_code_t code;
  logic      frame_done;

  pixel_t      img [IMG_H][IMG_W];
  lbp_code_t   exp_code_q [$];
  bit          exp_last_q [$];
  lbp_code_t   exp_c;
  bit          exp_l;
  logic [31:0] rng_state;
  int          cycle_cnt = 0;
  int          frames_seen = 0;

  lbp_top lbp_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_valid_i (pixel_valid),
    .pixel_i       (pixel),
    .frame_start_i (frame_start),
    .code_valid_o  (code_valid),
    .code_o        (code),
    .frame_done_o  (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Bilinear sample in 8.16, quad pointing along (sr, sc)
  function automatic int diag_sum(input int r, input int c, input int sr, input int sc);
    int s;
    s = int'(img[r + sr][c + sc]) * int'(W_NEAR);
    s = s + int'(img[r + sr][c + 2 * sc]) * int'(W_MID);
    s = s + int'(img[r + 2 * sr][c + sc]) * int'(W_MID);
    s = s + int'(img[r + 2 * sr][c + 2 * sc]) * int'(W_FAR);
    return s;
  endfunction

  function automatic lbp_code_t expected_code(input int r, input int c);
    int        ctr;
    int        smp [8];
    lbp_code_t res;
    ctr    = int'(img[r][c]) << 16;
    smp[0] = int'(img[r][c + 2]) << 16;
    smp[1] = diag_sum(r, c, -1, 1);
    smp[2] = int'(img[r - 2][c]) << 16;
    smp[3] = diag_sum(r, c, -1, -1);
    smp[4] = int'(img[r][c - 2]) << 16;
    smp[5] = diag_sum(r, c, 1, -1);
    smp[6] = int'(img[r + 2][c]) << 16;
    smp[7] = diag_sum(r, c, 1, 1);
    for (int i = 0; i < 8; i++) begin
      res[i] = (smp[i] >= ctr);
    end
    return res;
  endfunction

  task automatic fill_frame(input bit flat);
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        if (flat) begin
          img[r][c] = pixel_t'(100);
        end else begin
          rng_state = xorshift(rng_state);
          img[r][c] = rng_state[7:0];
        end
      end
    end
    // Interior centers in raster order
    for (int r = LBP_RADIUS; r < IMG_H - LBP_RADIUS; r++) begin
      for (int c = LBP_RADIUS; c < IMG_W - LBP_RADIUS; c++) begin
        exp_code_q.push_back(expected_code(r, c));
        exp_last_q.push_back((r == IMG_H - LBP_RADIUS - 1) && (c == IMG_W - LBP_RADIUS - 1));
      end
    end
  endtask

  task automatic send_frame(input bit gaps);
    int gap;
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        @(posedge clk);
        pixel_valid <= 1'b1;
        pixel       <= img[r][c];
        frame_start <= (r == 0) && (c == 0);
        if (gaps) begin
          rng_state = xorshift(rng_state);
          gap = rng_state[0] ? (int'(rng_state[9:8]) % 3) + 1 : 0;
          repeat (gap) begin
            @(posedge clk);
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
          end
        end
      end
    end
    @(posedge clk);
    pixel_valid <= 1'b0;
    frame_start <= 1'b0;
  endtask

  task automatic stop_with_error(input string msg);
    $display("Error: time %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      assert (!lbp_top_inst.lbp_top_sva_inst.any_fail)
        else stop_with_error("a bound timing or protocol assertion failed");
      if (code_valid) begin
        assert (exp_code_q.size() != 0)
          else stop_with_error("code_valid_o high with no code left to expect");
        exp_c = exp_code_q.pop_front();
        exp_l = exp_last_q.pop_front();
        assert (code == exp_c)
          else stop_with_error($sformatf("code %02h, expected %02h in frame %0d",
                                         code, exp_c, frames_seen + 1));
        // Flat frame gives all ones
        assert (frames_seen != 0 || code == 8'hFF)
          else stop_with_error($sformatf("flat frame code %02h, expected ff", code));
        assert (frame_done == exp_l)
          else stop_with_error($sformatf("frame_done_o %0b, expected %0b", frame_done, exp_l));
        if (frame_done) begin
          frames_seen <= frames_seen + 1;
        end
      end else begin
        assert (!frame_done)
          else stop_with_error("frame_done_o high without code_valid_o");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n       = 1'b0;
    pixel_valid = 1'b0;
    pixel       = '0;
    frame_start = 1'b0;
    rng_state   = 32'h85bf_7edb;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    fill_frame(1'b1);
    send_frame(1'b0);
    fill_frame(1'b0);
    send_frame(1'b0);
    fill_frame(1'b0);
    send_frame(1'b1);
    while (exp_code_q.size() != 0) begin
      @(posedge clk);
    end
    // Room for any stray output
    repeat (10) @(posedge clk);
    if (frames_seen != FRAMES || lbp_top_inst.lbp_top_sva_inst.any_fail) begin
      $display("Run ended with %0d frame_done pulses, expected %0d", frames_seen, FRAMES);
      $display("** FAIL **");
      $fatal(1, "wrong frame count at end of run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- lbp_top.f
hdl/lbp_pkg.sv
hdl/lbp_bilinear_calc.sv
hdl/lbp_window_buffer.sv
hdl/lbp_ring_interp.sv
hdl/lbp_encoder.sv
hdl/lbp_top.sv
tb/lbp_top_sva.sv
tb/tb_lbp_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_lbp_top \
  -f lbp_top.f \
  -o sim_lbp
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_lbp +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
